//--- verilog/stfwd_pkg.sv
package stfwd_pkg;

  // ----------------------------------------------------------------------
  // basic widths
  // ----------------------------------------------------------------------

  // data and address width
  localparam int unsigned XLEN = 32;

  // access width of a load or store
  typedef enum logic [1:0] {
    LS_BYTE = 2'b00,
    LS_HALF = 2'b01,
    LS_WORD = 2'b10
  } ldst_width_t;

  // ----------------------------------------------------------------------
  // store request and buffered record
  // ----------------------------------------------------------------------

  // incoming store, also the drain payload toward memory
  typedef struct packed {
    logic [XLEN-1:0] addr;
    ldst_width_t     width;
    logic [XLEN-1:0] value;
  } st_req_t;

  // one buffer slot, valid plus the request fields
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] addr;
    ldst_width_t     width;
    logic [XLEN-1:0] value;
  } st_rec_t;

  // load forwarding result
  typedef struct packed {
    logic            hit;
    logic [XLEN-1:0] value;
  } fwd_rsp_t;

  // stores whose address masks to zero sit in the reserved low 4 KiB
  // and never enter the lookup cache
  localparam logic [XLEN-1:0] FWD_MASK = 32'hFFFF_F000;

endpackage

//--- verilog/store_alloc.sv
`timescale 1ns/1ps

module store_alloc #(
  parameter int unsigned STBUFF_DEPTH = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // store input port
  input  logic                                st_valid_i,
  input  stfwd_pkg::st_req_t                  st_req_i,
  output logic                                st_ready_o,
  // valid bits of all entries, tail picked here
  input  logic [STBUFF_DEPTH-1:0]             tail_valid_i,
  // write port of the entry array
  output logic [STBUFF_DEPTH-1:0]             wr_en_o,
  output stfwd_pkg::st_req_t                  wr_req_o,
  // lookup cache record request
  output logic                                upd_o,
  output logic [$clog2(STBUFF_DEPTH)-1:0]     upd_idx_o
);

  localparam int unsigned IdxW = $clog2(STBUFF_DEPTH);

  // tail pointer, next slot to fill
  logic [IdxW-1:0] tail_q;
  logic            accept;

  // ----------------------------------------------------------------------
  // handshake
  // ----------------------------------------------------------------------

  // room only while the tail slot is empty
  assign st_ready_o = ~tail_valid_i[tail_q];
  assign accept     = st_valid_i & st_ready_o;

  // ----------------------------------------------------------------------
  // tail pointer
  // ----------------------------------------------------------------------

  // depth is a power of two, so plain wrap
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tail_q <= '0;
    end else if (accept) begin
      tail_q <= tail_q + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // entry write and cache record
  // ----------------------------------------------------------------------

  // one-hot strobe on the tail slot
  assign wr_en_o   = accept ? (STBUFF_DEPTH'(1) << tail_q) : '0;
  assign wr_req_o  = st_req_i;

  // cache records the same slot on the same edge
  assign upd_o     = accept;
  assign upd_idx_o = tail_q;

endmodule

//--- verilog/sb_entry.sv
`timescale 1ns/1ps

module sb_entry (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // write from the allocator
  input  logic               wr_en_i,
  input  stfwd_pkg::st_req_t wr_req_i,
  // clear from the drain side
  input  logic               clr_i,
  // current contents
  output stfwd_pkg::st_rec_t rec_o
);

  // occupancy flag
  logic               valid_q;
  // stored request
  stfwd_pkg::st_req_t req_q;

  // ----------------------------------------------------------------------
  // valid bit
  // ----------------------------------------------------------------------

  // write wins over clear, so a reused slot stays full
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (wr_en_i) begin
      valid_q <= 1'b1;
    end else if (clr_i) begin
      valid_q <= 1'b0;
    end
  end

  // payload, only meaningful while valid
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      req_q <= wr_req_i;
    end
  end

  // record view
  assign rec_o.valid = valid_q;
  assign rec_o.addr  = req_q.addr;
  assign rec_o.width = req_q.width;
  assign rec_o.value = req_q.value;

endmodule

//--- verilog/sb_drain.sv
`timescale 1ns/1ps

module sb_drain #(
  parameter int unsigned STBUFF_DEPTH = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // all entries
  input  stfwd_pkg::st_rec_t              recs_i [STBUFF_DEPTH],
  // one-hot clear toward the entries
  output logic [STBUFF_DEPTH-1:0]         clr_o,
  // memory drain port
  output logic                            mem_valid_o,
  output stfwd_pkg::st_req_t              mem_req_o,
  input  logic                            mem_ready_i,
  // indexed read for forwarding
  input  logic [$clog2(STBUFF_DEPTH)-1:0] rd_idx_i,
  output stfwd_pkg::st_rec_t              rd_rec_o
);

  localparam int unsigned IdxW = $clog2(STBUFF_DEPTH);

  // head pointer, oldest store
  logic [IdxW-1:0]    head_q;
  stfwd_pkg::st_rec_t head_rec;
  logic               pop;

  // ----------------------------------------------------------------------
  // head presentation
  // ----------------------------------------------------------------------

  assign head_rec    = recs_i[head_q];
  assign mem_valid_o = head_rec.valid;

  // strip the valid bit for the memory side
  assign mem_req_o.addr  = head_rec.addr;
  assign mem_req_o.width = head_rec.width;
  assign mem_req_o.value = head_rec.value;

  // ----------------------------------------------------------------------
  // pop and head advance
  // ----------------------------------------------------------------------

  assign pop   = mem_valid_o & mem_ready_i;
  // free the head slot at the edge of the handshake
  assign clr_o = pop ? (STBUFF_DEPTH'(1) << head_q) : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q <= '0;
    end else if (pop) begin
      head_q <= head_q + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // forwarding read
  // ----------------------------------------------------------------------

  // slot named by the lookup cache, same cycle
  assign rd_rec_o = recs_i[rd_idx_i];

endmodule

//--- verilog/l0_cache.sv
`timescale 1ns/1ps

module l0_cache #(
  parameter int unsigned STBUFF_DEPTH = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  // drop all lines
  input  logic                                  flush_i,
  // record request from the allocator
  input  logic                                  upd_i,
  input  logic [$clog2(STBUFF_DEPTH)-1:0]       upd_idx_i,
  input  logic [stfwd_pkg::XLEN-1:0]            upd_addr_i,
  // load lookup
  input  logic [stfwd_pkg::XLEN-1:0]            ld_addr_i,
  input  stfwd_pkg::ldst_width_t                ld_width_i,
  // indexed read of the store buffer
  output logic [$clog2(STBUFF_DEPTH)-1:0]       st_idx_o,
  input  stfwd_pkg::st_rec_t                    st_rec_i,
  // forwarding result
  output stfwd_pkg::fwd_rsp_t                   fwd_o
);

  localparam int unsigned IdxW = $clog2(STBUFF_DEPTH);
  localparam int unsigned TagW = stfwd_pkg::XLEN - IdxW;

  // one cache line
  typedef struct packed {
    logic            valid;
    logic [TagW-1:0] tag;
    logic [IdxW-1:0] st_idx;
  } line_t;

  line_t           lines_q [STBUFF_DEPTH];

  logic [IdxW-1:0] upd_line;
  logic [TagW-1:0] upd_tag;
  logic            upd_ok;
  logic [IdxW-1:0] ld_line;
  logic [TagW-1:0] ld_tag;
  line_t           ld_hit_line;
  logic            line_hit;
  logic            entry_hit;

  // ----------------------------------------------------------------------
  // table update
  // ----------------------------------------------------------------------

  // low bits pick the line, the rest is the tag
  assign upd_line = upd_addr_i[IdxW-1:0];
  assign upd_tag  = upd_addr_i[stfwd_pkg::XLEN-1 -: TagW];
  // reserved region never recorded
  assign upd_ok   = upd_i & ((upd_addr_i & stfwd_pkg::FWD_MASK) != '0);

  // flush wins over a same-cycle record
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < STBUFF_DEPTH; i++) begin
        lines_q[i] <= '0;
      end
    end else if (flush_i) begin
      for (int i = 0; i < STBUFF_DEPTH; i++) begin
        lines_q[i].valid <= 1'b0;
      end
    end else if (upd_ok) begin
      lines_q[upd_line] <= '{valid: 1'b1, tag: upd_tag, st_idx: upd_idx_i};
    end
  end

  // ----------------------------------------------------------------------
  // forwarding decision
  // ----------------------------------------------------------------------

  assign ld_line     = ld_addr_i[IdxW-1:0];
  assign ld_tag      = ld_addr_i[stfwd_pkg::XLEN-1 -: TagW];
  assign ld_hit_line = lines_q[ld_line];
  assign line_hit    = ld_hit_line.valid & (ld_hit_line.tag == ld_tag);
  assign st_idx_o    = ld_hit_line.st_idx;

  // pointed entry still live with the load's tag and width
  assign entry_hit = st_rec_i.valid
                   & (st_rec_i.addr[stfwd_pkg::XLEN-1 -: TagW] == ld_tag)
                   & (st_rec_i.width == ld_width_i);

  assign fwd_o.hit   = line_hit & entry_hit;
  // value zeroed on a miss
  assign fwd_o.value = fwd_o.hit ? st_rec_i.value : '0;

endmodule

//--- verilog/store_buffer_top.sv
`timescale 1ns/1ps

module store_buffer_top #(
  parameter int unsigned STBUFF_DEPTH = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,
  // store input
  input  logic                         st_valid_i,
  input  stfwd_pkg::st_req_t           st_req_i,
  output logic                         st_ready_o,
  // memory drain
  output logic                         mem_valid_o,
  output stfwd_pkg::st_req_t           mem_req_o,
  input  logic                         mem_ready_i,
  // load forwarding
  input  logic [stfwd_pkg::XLEN-1:0]   ld_addr_i,
  input  stfwd_pkg::ldst_width_t       ld_width_i,
  output stfwd_pkg::fwd_rsp_t          fwd_o
);

  localparam int unsigned IdxW = $clog2(STBUFF_DEPTH);

  // ----------------------------------------------------------------------
  // internal wiring
  // ----------------------------------------------------------------------

  // entry array view
  stfwd_pkg::st_rec_t      recs [STBUFF_DEPTH];
  logic [STBUFF_DEPTH-1:0] ent_valid;

  // allocator to entries and cache
  logic [STBUFF_DEPTH-1:0] wr_en;
  stfwd_pkg::st_req_t      wr_req;
  logic                    upd;
  logic [IdxW-1:0]         upd_idx;

  // drain to entries
  logic [STBUFF_DEPTH-1:0] clr;

  // cache indexed read
  logic [IdxW-1:0]         rd_idx;
  stfwd_pkg::st_rec_t      rd_rec;

  // ----------------------------------------------------------------------
  // allocator
  // ----------------------------------------------------------------------

  store_alloc #(
    .STBUFF_DEPTH (STBUFF_DEPTH)
  ) u_alloc (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .st_valid_i   (st_valid_i),
    .st_req_i     (st_req_i),
    .st_ready_o   (st_ready_o),
    .tail_valid_i (ent_valid),
    .wr_en_o      (wr_en),
    .wr_req_o     (wr_req),
    .upd_o        (upd),
    .upd_idx_o    (upd_idx)
  );

  // ----------------------------------------------------------------------
  // entry ring
  // ----------------------------------------------------------------------

  for (genvar g = 0; g < STBUFF_DEPTH; g++) begin : g_entry
    sb_entry u_entry (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .wr_en_i  (wr_en[g]),
      .wr_req_i (wr_req),
      .clr_i    (clr[g]),
      .rec_o    (recs[g])
    );
    // valid bits gathered for the allocator
    assign ent_valid[g] = recs[g].valid;
  end

  // ----------------------------------------------------------------------
  // drain and lookup cache
  // ----------------------------------------------------------------------

  sb_drain #(
    .STBUFF_DEPTH (STBUFF_DEPTH)
  ) u_drain (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .recs_i      (recs),
    .clr_o       (clr),
    .mem_valid_o (mem_valid_o),
    .mem_req_o   (mem_req_o),
    .mem_ready_i (mem_ready_i),
    .rd_idx_i    (rd_idx),
    .rd_rec_o    (rd_rec)
  );

  l0_cache #(
    .STBUFF_DEPTH (STBUFF_DEPTH)
  ) u_l0 (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .upd_i      (upd),
    .upd_idx_i  (upd_idx),
    .upd_addr_i (wr_req.addr),
    .ld_addr_i  (ld_addr_i),
    .ld_width_i (ld_width_i),
    .st_idx_o   (rd_idx),
    .st_rec_i   (rd_rec),
    .fwd_o      (fwd_o)
  );

endmodule

//--- bench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  // free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset held low for a few rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- bench/tb_store_buffer.sv
`timescale 1ns/1ps

module tb_store_buffer;

  localparam int unsigned STBUFF_DEPTH = 4;
  localparam int unsigned IDX_W        = $clog2(STBUFF_DEPTH);
  localparam int          CLK_PERIOD   = 8;
  localparam int          NUM_STEPS    = 40;

  // step kinds of the stimulus table
  typedef enum logic [2:0] {OP_STORE, OP_LOAD, OP_DRAIN, OP_HOLD, OP_FLUSH} op_t;

  // one table row, exp_hit only read on loads
  typedef struct packed {
    op_t                    op;
    logic [31:0]            addr;
    stfwd_pkg::ldst_width_t width;
    logic                   exp_hit;
  } step_t;

  logic clk;
  logic rst_n;
  logic flush;
  logic st_valid;
  logic st_ready;
  logic mem_valid;
  logic mem_ready;
  logic [31:0] ld_addr;
  stfwd_pkg::ldst_width_t ld_width;
  stfwd_pkg::st_req_t     st_req;
  stfwd_pkg::st_req_t     mem_req;
  stfwd_pkg::fwd_rsp_t    fwd;

  step_t steps [NUM_STEPS];
  step_t cur;
  int    n_steps;
  int    n_checks;
  int    n_val_errs;
  int    n_other_errs;
  logic [31:0] rng;
  logic  exp_ready;
  logic  exp_mvalid;
  stfwd_pkg::fwd_rsp_t exp_fwd;

  // ------------------------------------------------------------------
  // reference model state
  // ------------------------------------------------------------------

  // slot mirror plus ring pointers
  logic               m_valid [STBUFF_DEPTH];
  stfwd_pkg::st_req_t m_req   [STBUFF_DEPTH];
  logic [IDX_W-1:0]   m_head;
  logic [IDX_W-1:0]   m_tail;
  // lookup table lines
  logic               l_valid [STBUFF_DEPTH];
  logic [31-IDX_W:0]  l_tag   [STBUFF_DEPTH];
  logic [IDX_W-1:0]   l_idx   [STBUFF_DEPTH];
  // stores in drain order
  stfwd_pkg::st_req_t drain_q [$];

  tb_clkgen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (4)
  ) u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  store_buffer_top #(
    .STBUFF_DEPTH (STBUFF_DEPTH)
  ) dut_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .flush_i     (flush),
    .st_valid_i  (st_valid),
    .st_req_i    (st_req),
    .st_ready_o  (st_ready),
    .mem_valid_o (mem_valid),
    .mem_req_o   (mem_req),
    .mem_ready_i (mem_ready),
    .ld_addr_i   (ld_addr),
    .ld_width_i  (ld_width),
    .fwd_o       (fwd)
  );

  // xorshift32 step for store data
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected load result from the model tables
  function automatic stfwd_pkg::fwd_rsp_t model_fwd(input logic [31:0] addr,
                                                    input stfwd_pkg::ldst_width_t width);
    stfwd_pkg::fwd_rsp_t r;
    logic [IDX_W-1:0]    line;
    logic [IDX_W-1:0]    e;
    r    = '0;
    line = addr[IDX_W-1:0];
    e    = l_idx[line];
    if (l_valid[line] && l_tag[line] == addr[31:IDX_W] && m_valid[e]
        && m_req[e].addr[31:IDX_W] == addr[31:IDX_W] && m_req[e].width == width) begin
      r.hit   = 1'b1;
      r.value = m_req[e].value;
    end
    return r;
  endfunction

  // ------------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------------

  // value only meaningful on a hit
  task automatic check_fwd(input stfwd_pkg::fwd_rsp_t got, input stfwd_pkg::fwd_rsp_t exp,
                           input string name);
    n_checks++;
    if (got.hit !== exp.hit || (exp.hit && got.value !== exp.value)) begin
      n_val_errs++;
      $display("[FAIL] %0t %s got hit=%0b value=%h exp hit=%0b value=%h",
               $time, name, got.hit, got.value, exp.hit, exp.value);
    end
  endtask

  task automatic check_req(input stfwd_pkg::st_req_t got, input stfwd_pkg::st_req_t exp,
                           input string name);
    n_checks++;
    if (got !== exp) begin
      n_val_errs++;
      $display("[FAIL] %0t %s got addr=%h width=%0d value=%h exp addr=%h width=%0d value=%h",
               $time, name, got.addr, got.width, got.value, exp.addr, exp.width, exp.value);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    n_checks++;
    if (got !== exp) begin
      n_val_errs++;
      $display("[FAIL] %0t %s got %0b exp %0b", $time, name, got, exp);
    end
  endtask

  // ------------------------------------------------------------------
  // stimulus table
  // ------------------------------------------------------------------

  task automatic add_step(input op_t op, input logic [31:0] addr,
                          input stfwd_pkg::ldst_width_t width, input logic exp_hit);
    if (n_steps < NUM_STEPS) begin
      steps[n_steps].op      = op;
      steps[n_steps].addr    = addr;
      steps[n_steps].width   = width;
      steps[n_steps].exp_hit = exp_hit;
    end
    n_steps++;
  endtask

  task automatic build_table();
    // store, forward, replace
    add_step(OP_STORE, 32'h0000_2000, stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_LOAD,  32'h0000_2000, stfwd_pkg::LS_WORD, 1'b1);
    add_step(OP_STORE, 32'h0000_2000, stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_LOAD,  32'h0000_2000, stfwd_pkg::LS_WORD, 1'b1);
    // width mismatch, no record
    add_step(OP_LOAD,  32'h0000_2000, stfwd_pkg::LS_HALF, 1'b0);
    add_step(OP_LOAD,  32'h0000_3005, stfwd_pkg::LS_WORD, 1'b0);
    // reserved region store
    add_step(OP_STORE, 32'h0000_0800, stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_LOAD,  32'h0000_0800, stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_DRAIN, 32'h0,         stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_DRAIN, 32'h0,         stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_LOAD,  32'h0000_2000, stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_DRAIN, 32'h0,         stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_LOAD,  32'h0000_0800, stfwd_pkg::LS_WORD, 1'b0);
    // fill the ring with memory stalled
    add_step(OP_STORE, 32'h0000_4001, stfwd_pkg::LS_HALF, 1'b0);
    add_step(OP_STORE, 32'h0000_4002, stfwd_pkg::LS_BYTE, 1'b0);
    add_step(OP_STORE, 32'h0000_4003, stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_STORE, 32'h0000_4000, stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_STORE, 32'h0000_5000, stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_HOLD,  32'h0,         stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_LOAD,  32'h0000_4002, stfwd_pkg::LS_BYTE, 1'b1);
    add_step(OP_DRAIN, 32'h0,         stfwd_pkg::LS_WORD, 1'b0);
    // alias on line 0, newer store wins
    add_step(OP_STORE, 32'h0000_5000, stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_LOAD,  32'h0000_4000, stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_LOAD,  32'h0000_5000, stfwd_pkg::LS_WORD, 1'b1);
    // flush, then buffered stores still drain
    add_step(OP_FLUSH, 32'h0,         stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_LOAD,  32'h0000_5000, stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_LOAD,  32'h0000_4003, stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_DRAIN, 32'h0,         stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_DRAIN, 32'h0,         stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_DRAIN, 32'h0,         stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_DRAIN, 32'h0,         stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_DRAIN, 32'h0,         stfwd_pkg::LS_WORD, 1'b0);
    // reuse after full drain
    add_step(OP_STORE, 32'h0000_6004, stfwd_pkg::LS_BYTE, 1'b0);
    add_step(OP_LOAD,  32'h0000_6004, stfwd_pkg::LS_BYTE, 1'b1);
    add_step(OP_STORE, 32'h0000_6004, stfwd_pkg::LS_BYTE, 1'b0);
    add_step(OP_LOAD,  32'h0000_6004, stfwd_pkg::LS_BYTE, 1'b1);
    add_step(OP_DRAIN, 32'h0,         stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_LOAD,  32'h0000_6004, stfwd_pkg::LS_BYTE, 1'b1);
    add_step(OP_DRAIN, 32'h0,         stfwd_pkg::LS_WORD, 1'b0);
    add_step(OP_LOAD,  32'h0000_6004, stfwd_pkg::LS_BYTE, 1'b0);
  endtask

  // ------------------------------------------------------------------
  // model update at the coming rising edge
  // ------------------------------------------------------------------

  task automatic update_model(input logic ready, input logic head_valid);
    logic [IDX_W-1:0] line;
    line = st_req.addr[IDX_W-1:0];
    // pop frees the head slot
    if (mem_ready && head_valid) begin
      m_valid[m_head] = 1'b0;
      m_head          = m_head + 1'b1;
      void'(drain_q.pop_front());
    end
    if (st_valid && ready) begin
      m_valid[m_tail] = 1'b1;
      m_req[m_tail]   = st_req;
      drain_q.push_back(st_req);
      // low 4 KiB never recorded
      if (!flush && st_req.addr[31:12] != '0) begin
        l_valid[line] = 1'b1;
        l_tag[line]   = st_req.addr[31:IDX_W];
        l_idx[line]   = m_tail;
      end
      m_tail = m_tail + 1'b1;
    end
    if (flush) begin
      for (int i = 0; i < STBUFF_DEPTH; i++) begin
        l_valid[i] = 1'b0;
      end
    end
  endtask

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------

  initial begin
    flush     = 1'b0;
    st_valid  = 1'b0;
    st_req    = '0;
    mem_ready = 1'b0;
    ld_addr   = '0;
    ld_width  = stfwd_pkg::LS_BYTE;
    rng       = 32'd89339;
    n_steps   = 0;
    n_checks  = 0;
    n_val_errs   = 0;
    n_other_errs = 0;
    m_head    = '0;
    m_tail    = '0;
    for (int i = 0; i < STBUFF_DEPTH; i++) begin
      m_valid[i] = 1'b0;
      m_req[i]   = '0;
      l_valid[i] = 1'b0;
      l_tag[i]   = '0;
      l_idx[i]   = '0;
    end
    build_table();
    if (n_steps != NUM_STEPS) begin
      n_other_errs++;
      $display("stimulus table holds %0d steps instead of %0d", n_steps, NUM_STEPS);
    end

    @(posedge rst_n);
    for (int i = 0; i < n_steps && i < NUM_STEPS; i++) begin
      @(negedge clk);
      cur       = steps[i];
      st_valid  = 1'b0;
      flush     = 1'b0;
      mem_ready = 1'b0;
      case (cur.op)
        OP_STORE: begin
          rng          = xorshift32(rng);
          st_valid     = 1'b1;
          st_req.addr  = cur.addr;
          st_req.width = cur.width;
          st_req.value = rng;
        end
        OP_LOAD: begin
          ld_addr  = cur.addr;
          ld_width = cur.width;
        end
        OP_DRAIN: mem_ready = 1'b1;
        OP_FLUSH: flush = 1'b1;
        default: begin
        end
      endcase
      // outputs settled well before the rising edge
      #1;
      exp_ready  = !m_valid[m_tail];
      exp_mvalid = drain_q.size() != 0;
      check_bit(st_ready, exp_ready, "st_ready_o");
      check_bit(mem_valid, exp_mvalid, "mem_valid_o");
      if (exp_mvalid) begin
        check_req(mem_req, drain_q[0], "mem_req_o");
      end
      exp_fwd = model_fwd(ld_addr, ld_width);
      check_fwd(fwd, exp_fwd, "fwd_o");
      if (cur.op == OP_LOAD) begin
        check_bit(fwd.hit, cur.exp_hit, "fwd_o.hit (table)");
      end
      update_model(exp_ready, exp_mvalid);
    end
    @(negedge clk);

    $display("checks %0d, value errors %0d, other errors %0d",
             n_checks, n_val_errs, n_other_errs);
    if (n_val_errs == 0 && n_other_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    #((NUM_STEPS + 20) * CLK_PERIOD);
    $display("watchdog expired before the stimulus table finished");
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- verilog.f
verilog/stfwd_pkg.sv
verilog/store_alloc.sv
verilog/sb_entry.sv
verilog/sb_drain.sv
verilog/l0_cache.sv
verilog/store_buffer_top.sv
bench/tb_clkgen.sv
bench/tb_store_buffer.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
  && verilator --binary --timing --top-module tb_store_buffer -f verilog.f \
       -o sim_store_buffer \
  && ./obj_dir/sim_store_buffer | tee /dev/stderr | grep -qx "Testbench passed" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
exit 0
